//--- hdl/simt_frontend_config.svh
// Build-time sizes for the SIMT instruction front end
// Warp count and width, PC and instruction widths, memory depth
`ifndef SIMT_FRONTEND_CONFIG_SVH
`define SIMT_FRONTEND_CONFIG_SVH

// Number of warps held by the fetcher
`define SIMT_NUM_WARPS 4

// Threads per warp, one active-mask bit each
`define SIMT_WARP_WIDTH 8

// Word address of an instruction
`define SIMT_PC_WIDTH 8

// Raw encoded instruction
`define SIMT_INST_WIDTH 32

// Words in the instruction memory
// Covers the full PC range
`define SIMT_IMEM_DEPTH 256

`endif

//--- hdl/simt_pkg.sv
// Shared types of the SIMT front end
// Warp id, PC, active mask, raw and decoded instruction
`default_nettype none

`include "simt_frontend_config.svh"

package simt_pkg;

    // Warp identifier, wide enough for every warp
    typedef logic [$clog2(`SIMT_NUM_WARPS)-1:0] wid_t;

    // Instruction word address
    typedef logic [`SIMT_PC_WIDTH-1:0] pc_t;

    // One bit per thread of a warp
    typedef logic [`SIMT_WARP_WIDTH-1:0] act_mask_t;

    // Instruction as stored in memory
    typedef logic [`SIMT_INST_WIDTH-1:0] enc_inst_t;

    // Register file index
    typedef logic [7:0] reg_idx_t;

    // Decoded register fields
    // dst sits on top, then src[1] and src[0] in the packed layout
    typedef struct packed {
        reg_idx_t       dst;
        reg_idx_t [1:0] src;
    } dec_inst_t;

endpackage : simt_pkg

`default_nettype wire

//--- hdl/warp_fetcher.sv
// Warp fetcher of the SIMT front end
// Per-warp PC, mask, active and pending table with launch handling
// Round-robin pick of eligible warps into a registered fetch request
`timescale 1ns/1ps
`default_nettype none

`include "simt_frontend_config.svh"

module warp_fetcher (
    input  logic                clk_i,
    input  logic                reset_i,

    // Launch from outside
    input  logic                launch_i,
    input  simt_pkg::wid_t      launch_warp_id_i,
    input  simt_pkg::pc_t       launch_pc_i,
    input  simt_pkg::act_mask_t launch_act_mask_i,

    // Request to the instruction memory
    output logic                fetch_valid_o,
    output simt_pkg::pc_t       fetch_pc_o,
    output simt_pkg::act_mask_t fetch_act_mask_o,
    output simt_pkg::wid_t      fetch_warp_id_o,
    input  logic                mem_ready_i,

    // Feedback from the decoder
    input  logic                dec_decoded_i,
    input  logic                dec_stop_warp_i,
    input  simt_pkg::wid_t      dec_decoded_warp_id_i,
    input  simt_pkg::pc_t       dec_decoded_next_pc_i,

    output logic                done_o
);
    // Per-warp state
    simt_pkg::pc_t                pc_q   [`SIMT_NUM_WARPS];
    simt_pkg::act_mask_t          mask_q [`SIMT_NUM_WARPS];
    logic [`SIMT_NUM_WARPS-1:0]   active_q;
    logic [`SIMT_NUM_WARPS-1:0]   pending_q;
    logic [`SIMT_NUM_WARPS-1:0]   eligible;

    // Request register, its warp id doubles as the round-robin pointer
    logic           fetch_valid_q;
    simt_pkg::wid_t fetch_wid_q;

    logic           sel_valid;
    simt_pkg::wid_t sel_wid;
    logic           launch_accept;
    logic           fetch_fire;

    assign launch_accept = launch_i && !active_q[launch_warp_id_i];
    assign fetch_fire    = fetch_valid_q && mem_ready_i;

    // Active and not in flight, the warp already waiting in the request is skipped
    always_comb begin : eligibility
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            eligible[w] = active_q[w] && !pending_q[w]
                && !(fetch_valid_q && fetch_wid_q == simt_pkg::wid_t'(w));
        end
    end

    // Search starts at the warp after the last one granted
    always_comb begin : rr_pick
        int idx;
        sel_valid = 1'b0;
        sel_wid   = fetch_wid_q;
        for (int i = 1; i <= `SIMT_NUM_WARPS; i++) begin
            idx = (int'(fetch_wid_q) + i) % `SIMT_NUM_WARPS;
            if (!sel_valid && eligible[idx]) begin
                sel_valid = 1'b1;
                sel_wid   = simt_pkg::wid_t'(idx);
            end
        end
    end

    // Request held until the memory accepts it
    always_ff @(posedge clk_i) begin : request_reg
        if (reset_i) begin
            fetch_valid_q <= 1'b0;
            fetch_wid_q   <= simt_pkg::wid_t'(`SIMT_NUM_WARPS - 1);
        end else if (!fetch_valid_q || mem_ready_i) begin
            fetch_valid_q <= sel_valid;
            if (sel_valid) begin
                fetch_wid_q <= sel_wid;
            end
        end
    end

    // Active and pending flags
    always_ff @(posedge clk_i) begin : warp_flags
        if (reset_i) begin
            active_q  <= '0;
            pending_q <= '0;
        end else begin
            if (fetch_fire) begin
                pending_q[fetch_wid_q] <= 1'b1;
            end
            // Stop retires the warp, otherwise it may fetch again
            if (dec_decoded_i) begin
                if (dec_stop_warp_i) begin
                    active_q[dec_decoded_warp_id_i] <= 1'b0;
                end else begin
                    pending_q[dec_decoded_warp_id_i] <= 1'b0;
                end
            end
            if (launch_accept) begin
                active_q[launch_warp_id_i]  <= 1'b1;
                pending_q[launch_warp_id_i] <= 1'b0;
            end
        end
    end

    // PC and mask, only meaningful while the warp is active
    always_ff @(posedge clk_i) begin : warp_payload
        if (dec_decoded_i && !dec_stop_warp_i) begin
            pc_q[dec_decoded_warp_id_i] <= dec_decoded_next_pc_i;
        end
        if (launch_accept) begin
            pc_q[launch_warp_id_i]   <= launch_pc_i;
            mask_q[launch_warp_id_i] <= launch_act_mask_i;
        end
    end

    // Requested warp is not pending, so its table entry stays put
    assign fetch_valid_o    = fetch_valid_q;
    assign fetch_warp_id_o  = fetch_wid_q;
    assign fetch_pc_o       = pc_q[fetch_wid_q];
    assign fetch_act_mask_o = mask_q[fetch_wid_q];

    assign done_o = ~|active_q;

endmodule : warp_fetcher

`default_nettype wire

//--- hdl/inst_memory.sv
// Instruction memory of the SIMT front end
// Word array with a write strobe and a one-entry registered output stage
`timescale 1ns/1ps
`default_nettype none

`include "simt_frontend_config.svh"

module inst_memory (
    input  logic                clk_i,
    input  logic                reset_i,

    // Load port
    input  logic                imem_we_i,
    input  simt_pkg::pc_t       imem_addr_i,
    input  simt_pkg::enc_inst_t imem_wdata_i,

    // Requests from the fetcher
    input  logic                fetch_valid_i,
    input  simt_pkg::pc_t       fetch_pc_i,
    input  simt_pkg::act_mask_t fetch_act_mask_i,
    input  simt_pkg::wid_t      fetch_warp_id_i,
    output logic                mem_ready_o,

    // Output stage towards the decoder
    output logic                ic_valid_o,
    output simt_pkg::pc_t       ic_pc_o,
    output simt_pkg::act_mask_t ic_act_mask_o,
    output simt_pkg::wid_t      ic_warp_id_o,
    output simt_pkg::enc_inst_t ic_inst_o,
    input  logic                dec_ready_i
);
    simt_pkg::enc_inst_t mem_q [`SIMT_IMEM_DEPTH];

    logic                out_valid_q;
    simt_pkg::pc_t       out_pc_q;
    simt_pkg::act_mask_t out_mask_q;
    simt_pkg::wid_t      out_wid_q;
    simt_pkg::enc_inst_t out_inst_q;
    logic                fetch_fire;

    // Free slot, or the current entry leaves this cycle
    assign mem_ready_o = !out_valid_q || dec_ready_i;
    assign fetch_fire  = fetch_valid_i && mem_ready_o;

    always_ff @(posedge clk_i) begin : mem_write
        if (imem_we_i) begin
            mem_q[imem_addr_i] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin : out_valid_reg
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (fetch_fire) begin
            out_valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Word read together with the request's warp info
    always_ff @(posedge clk_i) begin : out_payload
        if (fetch_fire) begin
            out_inst_q <= mem_q[fetch_pc_i];
            out_pc_q   <= fetch_pc_i;
            out_mask_q <= fetch_act_mask_i;
            out_wid_q  <= fetch_warp_id_i;
        end
    end

    assign ic_valid_o    = out_valid_q;
    assign ic_pc_o       = out_pc_q;
    assign ic_act_mask_o = out_mask_q;
    assign ic_warp_id_o  = out_wid_q;
    assign ic_inst_o     = out_inst_q;

endmodule : inst_memory

`default_nettype wire

//--- hdl/decoder.sv
// Instruction decoder of the SIMT front end
// Register field split, stop detection and decoded-warp feedback
`timescale 1ns/1ps
`default_nettype none

`include "simt_frontend_config.svh"

module decoder #(
    parameter type dec_inst_t = simt_pkg::dec_inst_t
) (
    // From the instruction memory
    output logic                dec_ready_o,
    input  logic                ic_valid_i,
    input  simt_pkg::pc_t       ic_pc_i,
    input  simt_pkg::act_mask_t ic_act_mask_i,
    input  simt_pkg::wid_t      ic_warp_id_i,
    input  simt_pkg::enc_inst_t ic_inst_i,

    // To the dispatcher
    input  logic                disp_ready_i,
    output logic                dec_valid_o,
    output simt_pkg::pc_t       dec_pc_o,
    output simt_pkg::act_mask_t dec_act_mask_o,
    output simt_pkg::wid_t      dec_warp_id_o,
    output dec_inst_t           dec_inst_o,

    // Back to the fetcher
    output logic                dec_decoded_o,
    output logic                dec_stop_warp_o,
    output simt_pkg::wid_t      dec_decoded_warp_id_o,
    output simt_pkg::pc_t       dec_decoded_next_pc_o
);
    localparam int inst_w = `SIMT_INST_WIDTH;
    localparam int reg_w  = $bits(simt_pkg::reg_idx_t);

    logic stop_consumed;

    // Ready comes straight from the dispatcher
    assign dec_ready_o = disp_ready_i;

    // Warp info passes through unchanged
    assign dec_pc_o       = ic_pc_i;
    assign dec_act_mask_o = ic_act_mask_i;
    assign dec_warp_id_o  = ic_warp_id_i;

    // Stop marker is an all-ones low byte
    assign dec_stop_warp_o = &ic_inst_i[7:0];

    // Stop leaves the memory stage only once it is accepted
    assign stop_consumed = ic_valid_i && dec_stop_warp_o && dec_ready_o;

    // Stops never reach the dispatcher
    assign dec_valid_o = ic_valid_i && !dec_stop_warp_o;

    // Fetcher learns about dispatched instructions and consumed stops
    assign dec_decoded_o         = stop_consumed || (dec_valid_o && disp_ready_i);
    assign dec_decoded_warp_id_o = ic_warp_id_i;
    assign dec_decoded_next_pc_o = ic_pc_i + simt_pkg::pc_t'(1);

    // dst on top, then src[0] and src[1] going down
    always_comb begin : decode_fields
        dec_inst_o.dst    = ic_inst_i[inst_w-1 -: reg_w];
        dec_inst_o.src[0] = ic_inst_i[inst_w-1-reg_w -: reg_w];
        dec_inst_o.src[1] = ic_inst_i[inst_w-1-2*reg_w -: reg_w];
    end

endmodule : decoder

`default_nettype wire

//--- hdl/simt_frontend.sv
// Top level of the SIMT instruction front end
// Fetcher, instruction memory and decoder wired in a valid/ready chain
`timescale 1ns/1ps
`default_nettype none

module simt_frontend (
    input  logic                clk_i,
    input  logic                reset_i,

    // Instruction memory load
    input  logic                imem_we_i,
    input  simt_pkg::pc_t       imem_addr_i,
    input  simt_pkg::enc_inst_t imem_wdata_i,

    // Warp launch
    input  logic                launch_i,
    input  simt_pkg::wid_t      launch_warp_id_i,
    input  simt_pkg::pc_t       launch_pc_i,
    input  simt_pkg::act_mask_t launch_act_mask_i,

    // Dispatcher port
    input  logic                disp_ready_i,
    output logic                dec_valid_o,
    output simt_pkg::pc_t       dec_pc_o,
    output simt_pkg::act_mask_t dec_act_mask_o,
    output simt_pkg::wid_t      dec_warp_id_o,
    output simt_pkg::dec_inst_t dec_inst_o,

    output logic                done_o
);
    // Fetcher to memory
    logic                fetch_valid;
    simt_pkg::pc_t       fetch_pc;
    simt_pkg::act_mask_t fetch_act_mask;
    simt_pkg::wid_t      fetch_warp_id;
    logic                mem_ready;

    // Memory to decoder
    logic                ic_valid;
    simt_pkg::pc_t       ic_pc;
    simt_pkg::act_mask_t ic_act_mask;
    simt_pkg::wid_t      ic_warp_id;
    simt_pkg::enc_inst_t ic_inst;
    logic                dec_ready;

    // Decoder feedback to fetcher
    logic                dec_decoded;
    logic                dec_stop_warp;
    simt_pkg::wid_t      dec_decoded_warp_id;
    simt_pkg::pc_t       dec_decoded_next_pc;

    warp_fetcher i_warp_fetcher (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .launch_i              (launch_i),
        .launch_warp_id_i      (launch_warp_id_i),
        .launch_pc_i           (launch_pc_i),
        .launch_act_mask_i     (launch_act_mask_i),
        .fetch_valid_o         (fetch_valid),
        .fetch_pc_o            (fetch_pc),
        .fetch_act_mask_o      (fetch_act_mask),
        .fetch_warp_id_o       (fetch_warp_id),
        .mem_ready_i           (mem_ready),
        .dec_decoded_i         (dec_decoded),
        .dec_stop_warp_i       (dec_stop_warp),
        .dec_decoded_warp_id_i (dec_decoded_warp_id),
        .dec_decoded_next_pc_i (dec_decoded_next_pc),
        .done_o                (done_o)
    );

    inst_memory i_inst_memory (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .imem_we_i        (imem_we_i),
        .imem_addr_i      (imem_addr_i),
        .imem_wdata_i     (imem_wdata_i),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .fetch_act_mask_i (fetch_act_mask),
        .fetch_warp_id_i  (fetch_warp_id),
        .mem_ready_o      (mem_ready),
        .ic_valid_o       (ic_valid),
        .ic_pc_o          (ic_pc),
        .ic_act_mask_o    (ic_act_mask),
        .ic_warp_id_o     (ic_warp_id),
        .ic_inst_o        (ic_inst),
        .dec_ready_i      (dec_ready)
    );

    decoder #(
        .dec_inst_t (simt_pkg::dec_inst_t)
    ) i_decoder (
        .dec_ready_o           (dec_ready),
        .ic_valid_i            (ic_valid),
        .ic_pc_i               (ic_pc),
        .ic_act_mask_i         (ic_act_mask),
        .ic_warp_id_i          (ic_warp_id),
        .ic_inst_i             (ic_inst),
        .disp_ready_i          (disp_ready_i),
        .dec_valid_o           (dec_valid_o),
        .dec_pc_o              (dec_pc_o),
        .dec_act_mask_o        (dec_act_mask_o),
        .dec_warp_id_o         (dec_warp_id_o),
        .dec_inst_o            (dec_inst_o),
        .dec_decoded_o         (dec_decoded),
        .dec_stop_warp_o       (dec_stop_warp),
        .dec_decoded_warp_id_o (dec_decoded_warp_id),
        .dec_decoded_next_pc_o (dec_decoded_next_pc)
    );

endmodule : simt_frontend

`default_nettype wire

//--- verification/clk_rst_gen.sv
// Clock and reset source for the testbench
// 10 ns clock, synchronous reset held high for two cycles
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen #(
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic reset_o
);
    // Free-running clock, first rising edge at 5 ns
    initial begin : clock_source
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // Released just after a rising edge, in step with the other stimulus
    initial begin : reset_source
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule : clk_rst_gen

`default_nettype wire

//--- verification/tb_simt_frontend.sv
// Directed testbench for the SIMT instruction front end
// Program loader, launch and drain tasks, dispatch monitor against a reference queue
// Back-pressure hold checks, cycle timeout and summary
`timescale 1ns/1ps
`default_nettype none

`include "simt_frontend_config.svh"

module tb_simt_frontend;
    // Program lengths, each program ends in one extra stop word
    localparam int single_len     = 6;
    localparam int relaunch_a_len = 4;
    localparam int relaunch_b_len = 5;

    function automatic int multi_len(input int w);
        return 3 + 2 * w;
    endfunction

    // Every program runs once, the four-warp set twice
    function automatic int program_insts();
        int total;
        total = single_len + relaunch_a_len + relaunch_b_len + 3;
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            total += 2 * (multi_len(w) + 1);
        end
        return total;
    endfunction

    localparam int timeout_limit = 20 * program_insts() + 200;

    logic                clk;
    logic                reset;
    logic                imem_we;
    simt_pkg::pc_t       imem_addr;
    simt_pkg::enc_inst_t imem_wdata;
    logic                launch;
    simt_pkg::wid_t      launch_wid;
    simt_pkg::pc_t       launch_pc;
    simt_pkg::act_mask_t launch_mask;
    logic                disp_ready;
    logic                dec_valid;
    simt_pkg::pc_t       dec_pc;
    simt_pkg::act_mask_t dec_mask;
    simt_pkg::wid_t      dec_wid;
    simt_pkg::dec_inst_t dec_inst;
    logic                done;

    // Testbench copy of the memory, walked by the reference model
    simt_pkg::enc_inst_t image [`SIMT_IMEM_DEPTH];
    // Expected dispatches as {warp id, pc, mask, instruction}
    logic [49:0] exp_q [$];

    string  cur_test = "none";
    int     err_count = 0;
    int     check_count = 0;
    int     test_count = 0;
    int     test_errs = 0;
    int     exp_pushed = 0;
    int     disp_count = 0;
    int     cycle_count = 0;
    integer seed;

    // Monitor state
    logic        held = 1'b0;
    logic [41:0] held_payload;
    int          match_idx;
    logic [49:0] entry;

    clk_rst_gen i_clk_rst_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    simt_frontend i_dut (
        .clk_i             (clk),
        .reset_i           (reset),
        .imem_we_i         (imem_we),
        .imem_addr_i       (imem_addr),
        .imem_wdata_i      (imem_wdata),
        .launch_i          (launch),
        .launch_warp_id_i  (launch_wid),
        .launch_pc_i       (launch_pc),
        .launch_act_mask_i (launch_mask),
        .disp_ready_i      (disp_ready),
        .dec_valid_o       (dec_valid),
        .dec_pc_o          (dec_pc),
        .dec_act_mask_o    (dec_mask),
        .dec_warp_id_o     (dec_wid),
        .dec_inst_o        (dec_inst),
        .done_o            (done)
    );

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs  = err_count;
        exp_pushed = 0;
        disp_count = 0;
        test_count++;
    endtask

    task automatic finish_test();
        $display("%s: %0d dispatched, %0d errors", cur_test, disp_count, err_count - test_errs);
    endtask

    // Distinct fields per program, low byte never reaches the stop marker
    function automatic simt_pkg::enc_inst_t make_inst(input logic [7:0] tag, input int k);
        return {tag + 8'(k), tag ^ 8'(3 * k + 1), 8'hC0 + 8'(k), 8'(k)};
    endfunction

    // One write strobe per word, mirrored into the image
    task automatic load_word(input simt_pkg::pc_t addr, input simt_pkg::enc_inst_t data);
        imem_we    = 1'b1;
        imem_addr  = addr;
        imem_wdata = data;
        image[addr] = data;
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic load_program(input logic [7:0] tag, input simt_pkg::pc_t base,
                                input int len);
        for (int k = 0; k < len; k++) begin
            load_word(base + simt_pkg::pc_t'(k), make_inst(tag, k));
        end
        load_word(base + simt_pkg::pc_t'(len), {tag, 16'h0000, 8'hFF});
    endtask

    // Reference model, one dispatch per word from the launch PC up to the stop
    task automatic expect_program(input simt_pkg::wid_t w, input simt_pkg::pc_t base,
                                  input simt_pkg::act_mask_t mask);
        simt_pkg::pc_t pc;
        pc = base;
        while (image[pc][7:0] != 8'hFF) begin
            exp_q.push_back({w, pc, mask, image[pc]});
            exp_pushed++;
            pc++;
        end
    endtask

    function automatic int first_expected(input simt_pkg::wid_t w);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i][49:48] == w) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic launch_warp(input simt_pkg::wid_t w, input simt_pkg::pc_t pc,
                               input simt_pkg::act_mask_t mask);
        launch      = 1'b1;
        launch_wid  = w;
        launch_pc   = pc;
        launch_mask = mask;
        @(posedge clk);
        #1;
        launch = 1'b0;
    endtask

    // Runs until every warp is stopped and the model is empty
    task automatic wait_drain(input logic random_ready);
        logic finished;
        int   rnd;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #1;
            if (random_ready) begin
                rnd        = $random(seed);
                disp_ready = rnd[0];
            end
            finished = done && (exp_q.size() == 0);
        end
        disp_ready = 1'b1;
        // A few idle cycles so a late dispatch would still be caught
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Four programs at separate bases, one launch per cycle
    task automatic launch_four();
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            expect_program(simt_pkg::wid_t'(w), simt_pkg::pc_t'(32 * (w + 1)),
                           simt_pkg::act_mask_t'(8'h0F << w));
            launch_warp(simt_pkg::wid_t'(w), simt_pkg::pc_t'(32 * (w + 1)),
                        simt_pkg::act_mask_t'(8'h0F << w));
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        check("dec_valid_o", 0, dec_valid);
        check("done_o", 1, done);
        finish_test();
    endtask

    task automatic test_single_warp();
        start_test("single_warp");
        load_program(8'h10, 8'h10, single_len);
        expect_program(2'd1, 8'h10, 8'hA5);
        launch_warp(2'd1, 8'h10, 8'hA5);
        check("done_o after launch", 0, done);
        wait_drain(1'b0);
        check("dispatch count", single_len, disp_count);
        check("done_o", 1, done);
        finish_test();
    endtask

    task automatic test_four_warps();
        start_test("four_warps");
        for (int w = 0; w < `SIMT_NUM_WARPS; w++) begin
            load_program(8'h40 + 8'(16 * w), simt_pkg::pc_t'(32 * (w + 1)), multi_len(w));
        end
        launch_four();
        wait_drain(1'b0);
        check("dispatch count", exp_pushed, disp_count);
        check("done_o", 1, done);
        finish_test();
    endtask

    // Same programs as four_warps, still in memory
    task automatic test_back_pressure();
        start_test("back_pressure");
        launch_four();
        wait_drain(1'b1);
        check("dispatch count", exp_pushed, disp_count);
        check("done_o", 1, done);
        finish_test();
    endtask

    task automatic test_relaunch();
        start_test("relaunch");
        load_program(8'h90, 8'hA0, relaunch_a_len);
        load_program(8'hB0, 8'hC0, relaunch_b_len);
        expect_program(2'd2, 8'hA0, 8'h3C);
        disp_ready = 1'b0;
        launch_warp(2'd2, 8'hA0, 8'h3C);
        // Warp 2 is busy, this launch must leave its stream alone
        launch_warp(2'd2, 8'hC0, 8'h0F);
        disp_ready = 1'b1;
        wait_drain(1'b0);
        check("count before relaunch", relaunch_a_len, disp_count);
        expect_program(2'd2, 8'hC0, 8'hF0);
        launch_warp(2'd2, 8'hC0, 8'hF0);
        wait_drain(1'b0);
        check("count after relaunch", relaunch_a_len + relaunch_b_len, disp_count);
        check("done_o", 1, done);
        finish_test();
    endtask

    // Samples at the falling edge, between stimulus and the next capture edge
    always @(negedge clk) begin : dispatch_monitor
        if (!reset) begin
            // A stalled output must hold until it is taken
            if (held) begin
                check("held dec_valid_o", 1, dec_valid);
                check("held payload", held_payload, {dec_wid, dec_pc, dec_mask, dec_inst});
            end
            if (dec_valid && disp_ready) begin
                match_idx = first_expected(dec_wid);
                if (match_idx < 0) begin
                    err_count++;
                    $display("Error in %s: warp %0d dispatched PC %0h with nothing left to run",
                             cur_test, dec_wid, dec_pc);
                end else begin
                    entry = exp_q[match_idx];
                    exp_q.delete(match_idx);
                    check("pc", entry[47:40], dec_pc);
                    check("mask", entry[39:32], dec_mask);
                    check("dst", entry[31:24], dec_inst.dst);
                    check("src0", entry[23:16], dec_inst.src[0]);
                    check("src1", entry[15:8], dec_inst.src[1]);
                end
                disp_count++;
            end
            held         = dec_valid && !disp_ready;
            held_payload = {dec_wid, dec_pc, dec_mask, dec_inst};
        end
    end

    always @(posedge clk) begin : timeout_guard
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Error: run did not finish within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin : main
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        launch      = 1'b0;
        launch_wid  = '0;
        launch_pc   = '0;
        launch_mask = '0;
        disp_ready  = 1'b1;
        seed        = 32'h0585_2530;
        wait (reset == 1'b0);
        @(posedge clk);
        #1;
        test_reset();
        test_single_warp();
        test_four_warps();
        test_back_pressure();
        test_relaunch();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_simt_frontend

`default_nettype wire

//--- simt_frontend.f
+incdir+hdl
hdl/simt_pkg.sv
hdl/warp_fetcher.sv
hdl/inst_memory.sv
hdl/decoder.sv
hdl/simt_frontend.sv
verification/clk_rst_gen.sv
verification/tb_simt_frontend.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_simt_frontend
FILELIST  = simt_frontend.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
